/* Makefile */
# Verilator build for the memory pipe testbench
VERILATOR ?= verilator
TOP ?= tb_mem_pipe
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG ?= Something failed
PASS_MSG ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
design/mem_bus_pkg.sv
design/mem_pipe_pkg.sv
design/pipe_fifo.sv
design/mem_arbiter.sv
design/memory_port.sv
design/mem_pipe_top.sv
tests/mem_checker.sv
tests/tb_mem_pipe.sv

/* design/mem_arbiter.sv */
`default_nettype none

module mem_arbiter(
	input wire iBUS_CLOCK,
	input wire inRESET,
	// Instruction fetch
	input wire inst_req,
	input wire [mem_bus_pkg::ADDR_W-1:0] inst_addr,
	output logic inst_lock,
	// Data port
	input wire data_req,
	input wire [$bits(mem_bus_pkg::order_t)-1:0] data_order,
	input wire [mem_bus_pkg::MASK_W-1:0] data_mask,
	input wire data_rw,
	input wire [mem_bus_pkg::ADDR_W-1:0] data_addr,
	input wire [mem_bus_pkg::WORD_W-1:0] data_data,
	output logic data_lock,
	// Request queue
	output logic push,
	output mem_pipe_pkg::req_entry_t push_data,
	input wire full
);

	import mem_bus_pkg::*;
	import mem_pipe_pkg::*;

	src_t last_grant;
	logic grant_inst;
	logic grant_data;

	// Round robin where the loser of a tie waits one grant
	assign grant_inst = !full && inst_req && (!data_req || (last_grant == SRC_DATA));
	assign grant_data = !full && data_req && (!inst_req || (last_grant == SRC_INST));

	// Lock does not depend on own req
	assign inst_lock = full || (data_req && (last_grant == SRC_INST));
	assign data_lock = full || (inst_req && (last_grant == SRC_DATA));

	assign push = grant_inst || grant_data;

	// Build the queue entry
	always_comb begin
		if (grant_data) begin
			push_data.tag = SRC_DATA;
			push_data.order = order_t'(data_order);
			push_data.mask = data_mask;
			push_data.rw = data_rw;
			push_data.addr = data_addr;
			push_data.data = data_data;
		end
		else begin
			// Fetch is always a full word read
			push_data.tag = SRC_INST;
			push_data.order = ORDER_WORD;
			push_data.mask = '1;
			push_data.rw = 1'b0;
			push_data.addr = inst_addr;
			push_data.data = '0;
		end
	end

	// Remember who won last
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			// Fetch goes first after reset
			last_grant <= SRC_DATA;
		end
		else if (grant_inst) begin
			last_grant <= SRC_INST;
		end
		else if (grant_data) begin
			last_grant <= SRC_DATA;
		end
	end

	// Each accept seen by a requester writes an entry with its own tag
	// Two accepts in one cycle would need two tags in one push
	a_inst_grant: assert property (@(posedge iBUS_CLOCK) disable iff (!inRESET)
		(inst_req && !inst_lock) |-> (push && (push_data.tag == SRC_INST)));
	a_data_grant: assert property (@(posedge iBUS_CLOCK) disable iff (!inRESET)
		(data_req && !data_lock) |-> (push && (push_data.tag == SRC_DATA)));

endmodule

`default_nettype wire

/* design/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

	// External bus widths
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;
	// Read return is two words wide
	localparam int LINE_W = 64;
	localparam int MASK_W = 4;

	// Access order as it appears on the memory bus
	typedef enum logic [1:0] {
		ORDER_BYTE = 2'h0,
		ORDER_HALF = 2'h1,
		ORDER_WORD = 2'h2,
		ORDER_NONE = 2'h3
	} order_t;

	// Byte 0 goes to the top lane
	function automatic logic [WORD_W-1:0] swap_word(input logic [WORD_W-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Byte enables follow the swapped lanes
	function automatic logic [MASK_W-1:0] swap_mask(input logic [MASK_W-1:0] m);
		return {m[0], m[1], m[2], m[3]};
	endfunction

	// Each half swapped on its own, halves stay where they are
	function automatic logic [LINE_W-1:0] swap_line(input logic [LINE_W-1:0] l);
		return {swap_word(l[LINE_W-1:WORD_W]), swap_word(l[WORD_W-1:0])};
	endfunction

endpackage

`default_nettype wire

/* design/mem_pipe_pkg.sv */
`default_nettype none

package mem_pipe_pkg;

	// Who asked for a request
	typedef enum logic {
		SRC_INST = 1'b0,
		SRC_DATA = 1'b1
	} src_t;

	// One queued request, 72 bits
	typedef struct packed {
		src_t tag;
		mem_bus_pkg::order_t order;
		logic [mem_bus_pkg::MASK_W-1:0] mask;
		// 1 = write, 0 = read
		logic rw;
		logic [mem_bus_pkg::ADDR_W-1:0] addr;
		// Write data, don't care on reads
		logic [mem_bus_pkg::WORD_W-1:0] data;
	} req_entry_t;

	// Default request queue depth
	localparam int REQ_DEPTH_DEF = 4;
	// Default number of reads in flight
	localparam int TAG_DEPTH_DEF = 4;

endpackage

`default_nettype wire

/* design/mem_pipe_top.sv */
`default_nettype none

module mem_pipe_top #(
	parameter int REQ_DEPTH = mem_pipe_pkg::REQ_DEPTH_DEF,
	parameter int TAG_DEPTH = mem_pipe_pkg::TAG_DEPTH_DEF
)(
	input wire iBUS_CLOCK,
	input wire inRESET,
	// Instruction fetch
	input wire inst_req,
	input wire [mem_bus_pkg::ADDR_W-1:0] inst_addr,
	output logic inst_lock,
	output logic inst_valid,
	output logic [mem_bus_pkg::LINE_W-1:0] inst_data,
	input wire inst_busy,
	// Data port
	input wire data_req,
	input wire [$bits(mem_bus_pkg::order_t)-1:0] data_order,
	input wire [mem_bus_pkg::MASK_W-1:0] data_mask,
	input wire data_rw,
	input wire [mem_bus_pkg::ADDR_W-1:0] data_addr,
	input wire [mem_bus_pkg::WORD_W-1:0] data_data,
	output logic data_lock,
	output logic data_valid,
	output logic [mem_bus_pkg::LINE_W-1:0] data_rdata,
	input wire data_busy,
	output logic data_write_ack,
	// External memory bus
	output logic memory_req,
	input wire memory_lock,
	output logic [$bits(mem_bus_pkg::order_t)-1:0] memory_order,
	output logic [mem_bus_pkg::MASK_W-1:0] memory_mask,
	output logic memory_rw,
	output logic [mem_bus_pkg::ADDR_W-1:0] memory_addr,
	output logic [mem_bus_pkg::WORD_W-1:0] memory_data,
	input wire memory_valid,
	input wire [mem_bus_pkg::LINE_W-1:0] memory_rdata,
	output logic memory_busy
);

	import mem_pipe_pkg::*;

	// Arbiter to request queue
	logic req_push;
	req_entry_t req_push_data;
	logic req_full;
	// Request queue to memory port
	req_entry_t req_head;
	logic req_empty;
	logic req_pop;
	// Tag queue
	logic tag_push;
	src_t tag_push_data;
	logic tag_full;
	src_t tag_head;
	logic tag_empty;
	logic tag_pop;

	mem_arbiter arbiter(
		.iBUS_CLOCK(iBUS_CLOCK), .inRESET(inRESET),
		.inst_req(inst_req), .inst_addr(inst_addr), .inst_lock(inst_lock),
		.data_req(data_req), .data_order(data_order), .data_mask(data_mask),
		.data_rw(data_rw), .data_addr(data_addr), .data_data(data_data),
		.data_lock(data_lock),
		.push(req_push), .push_data(req_push_data), .full(req_full)
	);

	// Accepted requests wait here for the bus
	pipe_fifo #(.payload_t(req_entry_t), .DEPTH(REQ_DEPTH)) req_fifo(
		.iBUS_CLOCK(iBUS_CLOCK), .inRESET(inRESET),
		.push(req_push), .push_data(req_push_data), .full(req_full),
		.pop(req_pop), .head(req_head), .empty(req_empty)
	);

	// Owner of each read in flight, in issue order
	pipe_fifo #(.payload_t(src_t), .DEPTH(TAG_DEPTH)) tag_fifo(
		.iBUS_CLOCK(iBUS_CLOCK), .inRESET(inRESET),
		.push(tag_push), .push_data(tag_push_data), .full(tag_full),
		.pop(tag_pop), .head(tag_head), .empty(tag_empty)
	);

	memory_port port(
		.iBUS_CLOCK(iBUS_CLOCK), .inRESET(inRESET),
		.req_head(req_head), .req_empty(req_empty), .req_pop(req_pop),
		.tag_push(tag_push), .tag_push_data(tag_push_data), .tag_full(tag_full),
		.tag_head(tag_head), .tag_empty(tag_empty), .tag_pop(tag_pop),
		.memory_req(memory_req), .memory_lock(memory_lock),
		.memory_order(memory_order), .memory_mask(memory_mask),
		.memory_rw(memory_rw), .memory_addr(memory_addr), .memory_data(memory_data),
		.memory_valid(memory_valid), .memory_rdata(memory_rdata),
		.memory_busy(memory_busy),
		.inst_valid(inst_valid), .inst_data(inst_data), .inst_busy(inst_busy),
		.data_valid(data_valid), .data_rdata(data_rdata), .data_busy(data_busy),
		.data_write_ack(data_write_ack)
	);

endmodule

`default_nettype wire

/* design/memory_port.sv */
`default_nettype none

module memory_port(
	input wire iBUS_CLOCK,
	input wire inRESET,
	// Request queue
	input wire mem_pipe_pkg::req_entry_t req_head,
	input wire req_empty,
	output logic req_pop,
	// Tag queue, one entry per read in flight
	output logic tag_push,
	output mem_pipe_pkg::src_t tag_push_data,
	input wire tag_full,
	input wire mem_pipe_pkg::src_t tag_head,
	input wire tag_empty,
	output logic tag_pop,
	// External bus request
	output logic memory_req,
	input wire memory_lock,
	output logic [$bits(mem_bus_pkg::order_t)-1:0] memory_order,
	output logic [mem_bus_pkg::MASK_W-1:0] memory_mask,
	output logic memory_rw,
	output logic [mem_bus_pkg::ADDR_W-1:0] memory_addr,
	output logic [mem_bus_pkg::WORD_W-1:0] memory_data,
	// External bus return
	input wire memory_valid,
	input wire [mem_bus_pkg::LINE_W-1:0] memory_rdata,
	output logic memory_busy,
	// Instruction return
	output logic inst_valid,
	output logic [mem_bus_pkg::LINE_W-1:0] inst_data,
	input wire inst_busy,
	// Data return
	output logic data_valid,
	output logic [mem_bus_pkg::LINE_W-1:0] data_rdata,
	input wire data_busy,
	output logic data_write_ack
);

	import mem_bus_pkg::*;
	import mem_pipe_pkg::*;

	logic issue_ok;
	logic bus_take;
	logic ret_take;
	logic [LINE_W-1:0] ret_line;
	logic write_ack;

	// Reads need a free tag slot, writes behind them wait in the queue
	assign issue_ok = !req_empty && (req_head.rw || !tag_full);

	// Bus fields straight from the queue head
	assign memory_req = issue_ok;
	assign memory_order = req_head.order;
	assign memory_mask = swap_mask(req_head.mask);
	assign memory_rw = req_head.rw;
	assign memory_addr = req_head.addr;
	assign memory_data = swap_word(req_head.data);

	// Taken by the bus this cycle
	assign bus_take = memory_req && !memory_lock;
	assign req_pop = bus_take;

	// Remember the owner of every read
	assign tag_push = bus_take && !req_head.rw;
	assign tag_push_data = req_head.tag;

	// Write ack, one cycle after the bus takes a data write
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			write_ack <= 1'b0;
		end
		else begin
			write_ack <= bus_take && req_head.rw && (req_head.tag == SRC_DATA);
		end
	end

	assign data_write_ack = write_ack;

	// Return path
	assign ret_line = swap_line(memory_rdata);

	// Steer by the oldest outstanding read
	assign inst_valid = memory_valid && !tag_empty && (tag_head == SRC_INST);
	assign data_valid = memory_valid && !tag_empty && (tag_head == SRC_DATA);
	assign inst_data = ret_line;
	assign data_rdata = ret_line;

	// Bus waits on whoever owns the return
	assign memory_busy = (tag_head == SRC_INST) ? inst_busy : data_busy;

	// Retire the tag when the requester takes it
	assign ret_take = memory_valid && !tag_empty && !memory_busy;
	assign tag_pop = ret_take;

	// Memory must not answer a read we never issued
	a_ret_has_tag: assert property (@(posedge iBUS_CLOCK) disable iff (!inRESET)
		memory_valid |-> !tag_empty);

endmodule

`default_nettype wire

/* design/pipe_fifo.sv */
`default_nettype none

module pipe_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
)(
	input wire iBUS_CLOCK,
	input wire inRESET,
	// Write side
	input wire push,
	input wire payload_t push_data,
	output logic full,
	// Read side
	input wire pop,
	output payload_t head,
	output logic empty
);

	// Pointer needs at least one bit
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Storage
	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Write into storage, no reset on data
	always_ff @(posedge iBUS_CLOCK) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap at DEPTH
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Occupancy
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Oldest entry
	assign head = mem[rd_ptr];
	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// Callers must watch the flags
	a_no_overflow: assert property (@(posedge iBUS_CLOCK) disable iff (!inRESET)
		!(push && full));
	a_no_underflow: assert property (@(posedge iBUS_CLOCK) disable iff (!inRESET)
		!(pop && empty));

endmodule

`default_nettype wire

/* tests/mem_checker.sv */
`default_nettype none

module mem_checker #(
	parameter int N_REQ = 300,
	parameter int MAX_CYCLES = 20000
)(
	input wire iBUS_CLOCK,
	input wire inRESET,
	input wire inst_req,
	input wire [mem_bus_pkg::ADDR_W-1:0] inst_addr,
	input wire inst_lock,
	input wire inst_valid,
	input wire [mem_bus_pkg::LINE_W-1:0] inst_data,
	input wire inst_busy,
	input wire data_req,
	input wire [1:0] data_order,
	input wire [mem_bus_pkg::MASK_W-1:0] data_mask,
	input wire data_rw,
	input wire [mem_bus_pkg::ADDR_W-1:0] data_addr,
	input wire [mem_bus_pkg::WORD_W-1:0] data_data,
	input wire data_lock,
	input wire data_valid,
	input wire [mem_bus_pkg::LINE_W-1:0] data_rdata,
	input wire data_busy,
	input wire data_write_ack,
	input wire memory_req,
	input wire memory_lock,
	input wire [1:0] memory_order,
	input wire [mem_bus_pkg::MASK_W-1:0] memory_mask,
	input wire memory_rw,
	input wire [mem_bus_pkg::ADDR_W-1:0] memory_addr,
	input wire [mem_bus_pkg::WORD_W-1:0] memory_data,
	input wire memory_valid,
	input wire memory_busy,
	output int value_errors,
	output int other_errors,
	output logic done,
	output logic timed_out
);

	import mem_bus_pkg::*;

	// Expected bus fields plus expected return line
	typedef struct packed {
		logic is_data;
		logic [1:0] order;
		logic [MASK_W-1:0] mask;
		logic rw;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		logic [LINE_W-1:0] line;
	} exp_req_t;

	exp_req_t bus_q[$];
	logic [LINE_W-1:0] inst_q[$];
	logic [LINE_W-1:0] data_q[$];
	// Owner of each read on the bus in issue order
	logic owner_q[$];
	int accepted;
	int cycles;
	logic ack_due;
	logic inst_held;
	logic data_held;
	logic [LINE_W-1:0] inst_held_data;
	logic [LINE_W-1:0] data_held_data;

	// Byte 0 ends up in the top lane
	function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
		logic [31:0] r;
		for (int i = 0; i < 4; i++) begin
			r[8*i +: 8] = w[8*(3-i) +: 8];
		end
		return r;
	endfunction

	function automatic logic [3:0] reverse_mask(input logic [3:0] m);
		logic [3:0] r;
		for (int i = 0; i < 4; i++) begin
			r[i] = m[3-i];
		end
		return r;
	endfunction

	// Reference model of one accepted request
	function automatic exp_req_t expect_request(input logic is_data, input logic [1:0] order,
		input logic [3:0] mask, input logic rw, input logic [31:0] addr, input logic [31:0] wdata);
		exp_req_t e;
		e.is_data = is_data;
		e.addr = addr;
		if (is_data) begin
			e.order = order;
			e.mask = reverse_mask(mask);
			e.rw = rw;
			e.data = reverse_bytes(wdata);
		end
		else begin
			// Fetch is a full word read
			e.order = ORDER_WORD;
			e.mask = 4'hF;
			e.rw = 1'b0;
			e.data = '0;
		end
		// Memory gives A above its inverse and each half is swapped in place
		e.line = {reverse_bytes(addr), reverse_bytes(~addr)};
		return e;
	endfunction

	task automatic report_mismatch(input string msg);
		value_errors++;
		$display("Fail at time %0t: %s", $time, msg);
	endtask

	task automatic report_problem(input string msg);
		other_errors++;
		$display("Error at time %0t: %s", $time, msg);
	endtask

	initial begin
		value_errors = 0;
		other_errors = 0;
		done = 1'b0;
		timed_out = 1'b0;
		accepted = 0;
		cycles = 0;
		ack_due = 1'b0;
		inst_held = 1'b0;
		data_held = 1'b0;
	end

	always @(posedge iBUS_CLOCK) begin
		exp_req_t e;
		logic ack_next;
		logic owner;
		logic [LINE_W-1:0] want;
		ack_next = 1'b0;
		cycles++;
		if (cycles >= MAX_CYCLES && !timed_out) begin
			timed_out = 1'b1;
			$display("Timeout: run not finished after %0d cycles, %0d of %0d requests accepted",
				cycles, accepted, N_REQ);
			$display("Still expected: %0d bus, %0d fetch returns, %0d data returns",
				bus_q.size(), inst_q.size(), data_q.size());
		end
		// Quiet outputs until the first accept
		if (accepted == 0 && (memory_req || inst_valid || data_valid || data_write_ack)) begin
			report_mismatch("output active before any request was accepted");
		end
		if (inRESET) begin
			if (data_write_ack != ack_due) begin
				report_mismatch($sformatf("data_write_ack %0b, expected %0b", data_write_ack, ack_due));
			end
			// Held returns stay put
			if (inst_held && !(inst_valid && inst_data == inst_held_data)) begin
				report_mismatch("fetch return changed while busy");
			end
			if (data_held && !(data_valid && data_rdata == data_held_data)) begin
				report_mismatch("data return changed while busy");
			end
			// Routing and bus busy follow the oldest read on the bus
			if (memory_valid) begin
				if (owner_q.size() == 0) begin
					report_problem("memory returned data with no read on the bus");
				end
				else begin
					owner = owner_q[0];
					if (inst_valid != !owner || data_valid != owner ||
						memory_busy != (owner ? data_busy : inst_busy)) begin
						report_mismatch($sformatf("valid %b/%b busy %b, expected %b/%b busy %b",
							inst_valid, data_valid, memory_busy,
							!owner, owner, owner ? data_busy : inst_busy));
					end
					if (!memory_busy) begin
						void'(owner_q.pop_front());
					end
				end
			end
			else if (inst_valid || data_valid) begin
				report_mismatch("return valid while memory_valid is low");
			end
			// Bus take is checked before this edge's accepts
			if (memory_req && !memory_lock) begin
				if (bus_q.size() == 0) begin
					report_problem("bus took a request that was never accepted");
				end
				else begin
					e = bus_q.pop_front();
					if (memory_order != e.order || memory_mask != e.mask || memory_rw != e.rw ||
						memory_addr != e.addr || (e.rw && memory_data != e.data)) begin
						report_mismatch($sformatf("bus %h %h %b %h %h, expected %h %h %b %h %h",
							memory_order, memory_mask, memory_rw, memory_addr, memory_data,
							e.order, e.mask, e.rw, e.addr, e.data));
					end
					if (!e.rw) begin
						owner_q.push_back(e.is_data);
					end
					if (!e.rw && e.is_data) begin
						data_q.push_back(e.line);
					end
					else if (!e.rw) begin
						inst_q.push_back(e.line);
					end
					ack_next = e.rw && e.is_data;
				end
			end
			if (inst_req && !inst_lock && data_req && !data_lock) begin
				report_problem("both requesters accepted in one cycle");
			end
			if (inst_req && !inst_lock) begin
				bus_q.push_back(expect_request(1'b0, 2'b00, 4'h0, 1'b0, inst_addr, '0));
				accepted++;
			end
			if (data_req && !data_lock) begin
				bus_q.push_back(expect_request(1'b1, data_order, data_mask, data_rw,
					data_addr, data_data));
				accepted++;
			end
			// Returns
			if (inst_valid && !inst_busy) begin
				if (inst_q.size() == 0) begin
					report_problem("fetch return with no fetch outstanding");
				end
				else begin
					want = inst_q.pop_front();
					if (inst_data != want) begin
						report_mismatch($sformatf("fetch data %h, expected %h", inst_data, want));
					end
				end
			end
			if (data_valid && !data_busy) begin
				if (data_q.size() == 0) begin
					report_problem("data return with no data read outstanding");
				end
				else begin
					want = data_q.pop_front();
					if (data_rdata != want) begin
						report_mismatch($sformatf("data read %h, expected %h", data_rdata, want));
					end
				end
			end
		end
		ack_due = ack_next;
		inst_held = inRESET && inst_valid && inst_busy;
		inst_held_data = inst_data;
		data_held = inRESET && data_valid && data_busy;
		data_held_data = data_rdata;
		done = (accepted == N_REQ) && (bus_q.size() == 0) && (inst_q.size() == 0) &&
			(data_q.size() == 0) && !ack_due;
	end

endmodule

`default_nettype wire

/* tests/tb_mem_pipe.sv */
`default_nettype none

module tb_mem_pipe;

	import mem_bus_pkg::*;

	localparam int N_REQ = 300;
	// Worst case about 60 cycles per request, plus reset and drain
	localparam int MAX_CYCLES = N_REQ * 60 + 2000;

	logic iBUS_CLOCK;
	logic inRESET;
	// Instruction requester
	logic inst_req;
	logic [ADDR_W-1:0] inst_addr;
	logic inst_lock;
	logic inst_valid;
	logic [LINE_W-1:0] inst_data;
	logic inst_busy;
	// Data requester
	logic data_req;
	logic [1:0] data_order;
	logic [MASK_W-1:0] data_mask;
	logic data_rw;
	logic [ADDR_W-1:0] data_addr;
	logic [WORD_W-1:0] data_data;
	logic data_lock;
	logic data_valid;
	logic [LINE_W-1:0] data_rdata;
	logic data_busy;
	logic data_write_ack;
	// External bus
	logic memory_req;
	logic memory_lock;
	logic [1:0] memory_order;
	logic [MASK_W-1:0] memory_mask;
	logic memory_rw;
	logic [ADDR_W-1:0] memory_addr;
	logic [WORD_W-1:0] memory_data;
	logic memory_valid;
	logic [LINE_W-1:0] memory_rdata;
	logic memory_busy;
	// Results from the checker
	int value_errors;
	int other_errors;
	logic done;
	logic timed_out;

	// Stimulus state
	logic [31:0] rng_state = 32'd34;
	int raised = 0;
	int ret_delay = 0;
	logic inst_acc = 1'b0;
	logic data_acc = 1'b0;
	logic ret_taken = 1'b0;
	// Read addresses in bus issue order
	logic [ADDR_W-1:0] pend_addr[$];

	mem_pipe_top dut(.*);

	mem_checker #(.N_REQ(N_REQ), .MAX_CYCLES(MAX_CYCLES)) scoreboard(.*);

	always #50 iBUS_CLOCK = ~iBUS_CLOCK;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Low LCG bits are weak, use the upper half
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[31:16]) % n;
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[31:16], lo[31:16]};
	endfunction

	// What the DUT and the bus took at this edge
	always @(posedge iBUS_CLOCK) begin
		if (memory_req && !memory_lock && !memory_rw) begin
			pend_addr.push_back(memory_addr);
		end
		ret_taken = memory_valid && !memory_busy;
		inst_acc = inst_req && !inst_lock;
		data_acc = data_req && !data_lock;
	end

	task automatic drive_cycle();
		// Memory model, returns in issue order
		if (ret_taken) begin
			memory_valid = 1'b0;
			void'(pend_addr.pop_front());
			ret_delay = rand_below(4);
		end
		if (!memory_valid && pend_addr.size() > 0) begin
			if (ret_delay == 0) begin
				memory_valid = 1'b1;
				// Address on top, its inverse below
				memory_rdata = {pend_addr[0], ~pend_addr[0]};
			end
			else begin
				ret_delay--;
			end
		end
		memory_lock = (rand_below(4) == 0);
		inst_busy = (rand_below(4) == 0);
		data_busy = (rand_below(3) == 0);
		// New fetch only once the old one is taken
		if (inst_acc || !inst_req) begin
			inst_req = 1'b0;
			if (raised < N_REQ && rand_below(3) != 0) begin
				inst_req = 1'b1;
				inst_addr = rand_word() & 32'hFFFF_FFFC;
				raised++;
			end
		end
		if (data_acc || !data_req) begin
			data_req = 1'b0;
			if (raised < N_REQ && rand_below(3) != 0) begin
				data_req = 1'b1;
				data_order = 2'(rand_below(4));
				data_mask = 4'(rand_below(16));
				data_rw = (rand_below(2) == 1);
				data_addr = rand_word();
				data_data = rand_word();
				raised++;
			end
		end
	endtask

	initial begin
		iBUS_CLOCK = 1'b0;
		inRESET = 1'b0;
		inst_req = 1'b0;
		inst_addr = '0;
		inst_busy = 1'b0;
		data_req = 1'b0;
		data_order = '0;
		data_mask = '0;
		data_rw = 1'b0;
		data_addr = '0;
		data_data = '0;
		data_busy = 1'b0;
		memory_lock = 1'b0;
		memory_valid = 1'b0;
		memory_rdata = '0;
		repeat (2) @(posedge iBUS_CLOCK);
		@(negedge iBUS_CLOCK);
		inRESET = 1'b1;
		forever begin
			@(negedge iBUS_CLOCK);
			drive_cycle();
		end
	end

	initial begin
		wait (done || timed_out);
		// Room for a stray ack or return
		repeat (4) @(posedge iBUS_CLOCK);
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0 && !timed_out) begin
			$display("Everything OK");
		end
		else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
